// File: include/align_defs.svh
// Line aligner parameters
`ifndef ALIGN_DEFS_SVH
`define ALIGN_DEFS_SVH

// Number of 32-bit elements in one 512-bit cache line
`define ALIGN_ELEMS_PER_LINE 16

// Width of one data element in bits
`define ALIGN_ELEM_BITS 32

// Latency of the element shifter, 15 shift stages plus the output register
`define ALIGN_SHIFT_DEPTH 16

`endif

// File: hdl/alignTypesPkg.sv
// Line aligner vector types
`include "align_defs.svh"

package alignTypesPkg;

    // One data element of the stream
    typedef logic [`ALIGN_ELEM_BITS-1:0] elemT;

    // One cache line, element 0 in the low bits
    typedef logic [`ALIGN_ELEMS_PER_LINE*`ALIGN_ELEM_BITS-1:0] lineT;

    // Two adjacent lines, the later line sits in the upper half
    typedef logic [2*`ALIGN_ELEMS_PER_LINE*`ALIGN_ELEM_BITS-1:0] windowT;

    typedef logic [$clog2(`ALIGN_ELEMS_PER_LINE)-1:0] offsT; // Element offset or shifts left
    typedef logic [15:0] elemCountT;                          // Packet length in elements
    typedef logic [11:0] lineCountT;                          // Line index within a packet

    // One valid bit per element lane
    typedef logic [`ALIGN_ELEMS_PER_LINE-1:0] maskT;

    // Window builder states
    typedef enum logic [1:0] {
        IDLE,  // Waiting for the first line of a packet
        FILL,  // Inside a packet, previous line held
        FLUSH  // Last line held, its window goes out now
    } builderStateT;

endpackage

// File: hdl/alignStreamPkg.sv
// Line aligner stage beats
package alignStreamPkg;

    import alignTypesPkg::*;

    // Beat from the window builder into the shifter
    typedef struct packed {
        windowT    data;  // Line k+1 over line k
        offsT      offs;  // Elements still to shift out of the bottom
        elemCountT elems; // Packet length, needed later for masking
        logic      last;  // Final window of the packet
    } windowBeatT;

    // Beat from the shifter into the masker
    typedef struct packed {
        lineT      data;  // Aligned line, packet element 16k in lane 0
        elemCountT elems; // Packet length in elements
        logic      last;  // Final line of the packet
    } shiftedBeatT;

endpackage

// File: hdl/windowBuilder.sv
// Window builder stage
`include "align_defs.svh"

module windowBuilder (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       inValid,
    input  logic                       inLast,
    input  alignTypesPkg::lineT        inData,
    input  alignTypesPkg::offsT        inOffs,
    input  alignTypesPkg::elemCountT   inElems,
    output logic                       winValid,
    output alignStreamPkg::windowBeatT win,
    output logic                       lenError
);

    import alignTypesPkg::*;

    builderStateT state;
    builderStateT stateNext;
    lineT         prevLine;   // Line k, waiting for line k+1
    offsT         pktOffs;    // Offset of the packet in progress
    elemCountT    pktElems;   // Element count of the packet in progress
    lineCountT    pktLines;   // Lines the packet should have
    lineCountT    lineCnt;    // Lines seen so far in this packet
    logic         firstLine;  // An arriving line would open a new packet
    logic [15:0]  spanNow;    // Offset plus count, rounded up to a full line
    lineCountT    expNow;     // Expected lines from the inputs of this cycle
    lineCountT    expCur;     // Expected lines for the packet this line belongs to
    lineCountT    cntCur;     // Line count including the arriving line
    windowT       winData;
    offsT         winOffs;
    elemCountT    winElems;
    logic         winLast;

    // Only IDLE and FLUSH take a fresh packet, FILL is always mid-packet
    assign firstLine = (state != FILL);

    // Lines covered are ceil((offs + elems) / 16), the 12-bit line index bounds the packet size
    assign spanNow = 16'(inOffs) + inElems + 16'(`ALIGN_ELEMS_PER_LINE - 1);
    assign expNow  = spanNow[15:4];
    assign expCur  = firstLine ? expNow : pktLines;
    assign cntCur  = firstLine ? lineCountT'(1) : lineCnt + lineCountT'(1);

    always_comb begin
        stateNext = state;
        case (state)
            IDLE: begin
                if (inValid) begin
                    stateNext = inLast ? FLUSH : FILL; // Single-line packets flush at once
                end
            end
            FILL: begin
                if (inValid && inLast) begin
                    stateNext = FLUSH;
                end
            end
            FLUSH: begin
                // The next packet may start right in the flush cycle
                if (inValid) begin
                    stateNext = inLast ? FLUSH : FILL;
                end else begin
                    stateNext = IDLE;
                end
            end
            default: stateNext = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state    <= IDLE;
            winValid <= 1'b0;
            winLast  <= 1'b0;
            lenError <= 1'b0;
            lineCnt  <= '0;
        end else begin
            state    <= stateNext;
            winValid <= (state == FLUSH) || (state == FILL && inValid); // First lines only get stored
            winLast  <= (state == FLUSH);                                // The flush window closes a packet
            if (inValid) begin
                lineCnt <= cntCur;
            end
            if (inValid && inLast && (cntCur != expCur)) begin
                lenError <= 1'b1; // Sticky until the next reset
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == FLUSH) begin
            winData <= {lineT'(0), prevLine}; // Held last line over an empty upper half
        end else begin
            winData <= {inData, prevLine};
        end
        winOffs  <= pktOffs;  // Still the old packet when a new one opens in FLUSH
        winElems <= pktElems;
        if (inValid) begin
            prevLine <= inData;
            if (firstLine) begin
                pktOffs  <= inOffs;
                pktElems <= inElems;
                pktLines <= expNow;
            end
        end
    end

    assign win = '{data: winData, offs: winOffs, elems: winElems, last: winLast};

    // Nothing leaves the builder in the first clock after reset is released
    assert property (@(posedge clk) $rose(rstN) |-> !winValid);

    // Between packets inLast only comes together with a line
    assert property (@(posedge clk) disable iff (!rstN)
        (state == IDLE && inLast) |-> inValid);

endmodule

// File: hdl/elementShifter.sv
// Pipelined element shifter
`include "align_defs.svh"

module elementShifter (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic                        winValid,
    input  alignStreamPkg::windowBeatT  win,
    output logic                        shValid,
    output alignStreamPkg::shiftedBeatT sh
);

    import alignTypesPkg::*;

    localparam int numStages = `ALIGN_SHIFT_DEPTH - 1; // Output register adds the last cycle
    localparam int elemBits  = `ALIGN_ELEM_BITS;

    windowT    stData  [numStages];
    offsT      stOffs  [numStages];
    elemCountT stElems [numStages];
    logic      stValid [numStages];
    logic      stLast  [numStages];
    lineT      shData;
    elemCountT shElems;
    logic      shLast;

    // Drops element 0 of a window and fills zeros in at the top
    function automatic windowT dropElem(windowT w);
        return {elemT'(0), w[$bits(windowT)-1:elemBits]};
    endfunction

    always_ff @(posedge clk) begin
        // First stage works straight on the builder's window
        if (win.offs != '0) begin
            stData[0] <= dropElem(win.data);
            stOffs[0] <= win.offs - offsT'(1);
        end else begin
            stData[0] <= win.data;
            stOffs[0] <= win.offs;
        end
        stElems[0] <= win.elems;

        // Each later stage removes at most one more element
        for (int i = 1; i < numStages; i++) begin
            if (stOffs[i-1] != '0) begin
                stData[i] <= dropElem(stData[i-1]);
                stOffs[i] <= stOffs[i-1] - offsT'(1);
            end else begin
                stData[i] <= stData[i-1];
                stOffs[i] <= stOffs[i-1];
            end
            stElems[i] <= stElems[i-1];
        end

        shData  <= stData[numStages-1][$bits(lineT)-1:0]; // Aligned line is the lower half
        shElems <= stElems[numStages-1];
    end

    // Valid and last walk alongside the data with the same depth
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < numStages; i++) begin
                stValid[i] <= 1'b0;
                stLast[i]  <= 1'b0;
            end
            shValid <= 1'b0;
            shLast  <= 1'b0;
        end else begin
            stValid[0] <= winValid;
            stLast[0]  <= winValid && win.last;
            for (int i = 1; i < numStages; i++) begin
                stValid[i] <= stValid[i-1];
                stLast[i]  <= stLast[i-1];
            end
            shValid <= stValid[numStages-1];
            shLast  <= stLast[numStages-1];
        end
    end

    assign sh = '{data: shData, elems: shElems, last: shLast};

    // Fifteen stages are enough for any offset from 0 to 15
    assert property (@(posedge clk) disable iff (!rstN)
        stValid[numStages-1] |-> (stOffs[numStages-1] == '0));

endmodule

// File: hdl/lineMasker.sv
// Output line masker
`include "align_defs.svh"

module lineMasker (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic                        shValid,
    input  alignStreamPkg::shiftedBeatT sh,
    output logic                        outValid,
    output logic                        outLast,
    output alignTypesPkg::lineT         outData,
    output alignTypesPkg::maskT         outMask
);

    import alignTypesPkg::*;

    localparam int elemsPerLine = `ALIGN_ELEMS_PER_LINE;
    localparam int elemBits     = `ALIGN_ELEM_BITS;

    lineCountT   lineIdx;    // Index of the arriving line within its packet
    logic [16:0] lineBase;   // Packet element index held in lane 0
    maskT        laneMask;
    lineT        maskedData;

    assign lineBase = 17'(lineIdx) * 17'(elemsPerLine);

    always_comb begin
        for (int j = 0; j < elemsPerLine; j++) begin
            laneMask[j] = (lineBase + 17'(j)) < 17'(sh.elems); // Lane holds a real element
            // Lanes past the packet end go out as zero
            maskedData[j*elemBits +: elemBits] =
                laneMask[j] ? sh.data[j*elemBits +: elemBits] : elemT'(0);
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            lineIdx  <= '0;
            outValid <= 1'b0;
            outLast  <= 1'b0;
        end else begin
            outValid <= shValid;
            outLast  <= shValid && sh.last;
            if (shValid) begin
                lineIdx <= sh.last ? '0 : lineIdx + lineCountT'(1); // Next packet starts at line 0
            end
        end
    end

    always_ff @(posedge clk) begin
        outData <= maskedData;
        outMask <= laneMask;
    end

    // Every packet holds at least one element, so its first line has lane 0 valid
    assert property (@(posedge clk) disable iff (!rstN)
        (shValid && lineIdx == '0) |=> (outValid && outMask[0]));

endmodule

// File: hdl/lineAligner.sv
// Cache line realigner top
module lineAligner (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic                     inValid,
    input  logic                     inLast,
    input  alignTypesPkg::lineT      inData,
    input  alignTypesPkg::offsT      inOffs,
    input  alignTypesPkg::elemCountT inElems,
    output logic                     outValid,
    output logic                     outLast,
    output alignTypesPkg::lineT      outData,
    output alignTypesPkg::maskT      outMask,
    output logic                     lenError
);

    import alignStreamPkg::*;

    logic        winValid;
    windowBeatT  win;       // Builder to shifter, one window per output line
    logic        shValid;
    shiftedBeatT sh;        // Shifter to masker, 16 cycles later

    // Decode pairs lines into windows and checks the packet length
    windowBuilder i_windowBuilder (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (inValid),
        .inLast   (inLast),
        .inData   (inData),
        .inOffs   (inOffs),
        .inElems  (inElems),
        .winValid (winValid),
        .win      (win),
        .lenError (lenError)
    );

    // Execute moves packet element 0 down into lane 0
    elementShifter i_elementShifter (
        .clk      (clk),
        .rstN     (rstN),
        .winValid (winValid),
        .win      (win),
        .shValid  (shValid),
        .sh       (sh)
    );

    // Result counts lines and clears lanes past the packet end
    lineMasker i_lineMasker (
        .clk      (clk),
        .rstN     (rstN),
        .shValid  (shValid),
        .sh       (sh),
        .outValid (outValid),
        .outLast  (outLast),
        .outData  (outData),
        .outMask  (outMask)
    );

endmodule

// File: bench/clockGen.sv
// Testbench clock and reset
module clockGen (
    input  logic resetReq,
    output logic clk,
    output logic rstN
);

    timeunit 1ns;
    timeprecision 1ps;

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Reset for the first 3 cycles, and again for 3 cycles on each request
    initial begin
        rstN <= 1'b0; // The change from X gives the DUT a clean falling edge
        repeat (3) @(posedge clk);
        rstN <= 1'b1;
        forever begin
            @(posedge clk);
            if (resetReq) begin
                rstN <= 1'b0;
                repeat (3) @(posedge clk);
                rstN <= 1'b1;
            end
        end
    end

endmodule

// File: bench/lineAlignerTb.sv
// Line aligner testbench
`include "align_defs.svh"

module lineAlignerTb;

    timeunit 1ns;
    timeprecision 1ps;

    import alignTypesPkg::*;

    localparam int elemsPerLine = `ALIGN_ELEMS_PER_LINE;
    localparam int elemBits     = `ALIGN_ELEM_BITS;

    // One expected output line with the cycle it is due in
    typedef struct packed {
        lineT        data;
        maskT        mask;
        logic        last;
        int unsigned dueEdge;
    } expLineT;

    logic      clk;
    logic      rstN;
    logic      resetReq;
    logic      inValid;
    logic      inLast;
    lineT      inData;
    offsT      inOffs;
    elemCountT inElems;
    logic      outValid;
    logic      outLast;
    lineT      outData;
    maskT      outMask;
    logic      lenError;

    expLineT     expQ[$];        // Model output, oldest line first
    elemT        pktBuf[$];      // All elements of the packet being sent
    int unsigned edgeCnt    = 0; // Rising edges so far, updated at the falling edge
    int unsigned stimCycles = 0; // Cycles driven by the stimulus
    int          errCount   = 0;
    int          linesSeen  = 0;
    int          lastSeen   = 0;
    int          linesSent  = 0;
    int          testsRun   = 0;
    int          testErr0;
    int          testLines0;

    clockGen i_clockGen (
        .resetReq (resetReq),
        .clk      (clk),
        .rstN     (rstN)
    );

    lineAligner i_lineAligner (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (inValid),
        .inLast   (inLast),
        .inData   (inData),
        .inOffs   (inOffs),
        .inElems  (inElems),
        .outValid (outValid),
        .outLast  (outLast),
        .outData  (outData),
        .outMask  (outMask),
        .lenError (lenError)
    );

    // Lines a packet spans from its offset and element count
    function automatic int linesFor(int offs, int elems);
        return (offs + elems + elemsPerLine - 1) / elemsPerLine;
    endfunction

    // Output line k takes packet element offs + 16k + j into lane j
    function automatic expLineT modelLine(int k, int offs, int elems, logic last,
                                          int unsigned due);
        expLineT e;
        int      idx;
        e.data = '0;
        e.mask = '0;
        for (int j = 0; j < elemsPerLine; j++) begin
            idx = offs + elemsPerLine * k + j;
            if (elemsPerLine * k + j < elems) begin
                e.mask[j] = 1'b1;
                if (idx < pktBuf.size()) begin
                    e.data[j*elemBits +: elemBits] = pktBuf[idx]; // Past the sent data stays zero
                end
            end
        end
        e.last    = last;
        e.dueEdge = due;
        return e;
    endfunction

    function automatic lineT randomLine();
        lineT line;
        for (int j = 0; j < elemsPerLine; j++) begin
            line[j*elemBits +: elemBits] = elemT'($urandom);
        end
        return line;
    endfunction

    // Idle cycle, with junk on the inputs that the DUT must ignore
    task automatic driveIdle();
        @(posedge clk);
        inValid <= 1'b0;
        inLast  <= 1'b0;
        inData  <= randomLine();
        inOffs  <= offsT'($urandom);
        inElems <= elemCountT'($urandom);
        stimCycles++;
    endtask

    // Sends nSent lines, random gaps of up to maxGap cycles between them
    task automatic sendPacket(input int offs, input int elems, input int nSent,
                              input int maxGap);
        lineT        line;
        int unsigned driveEdge;
        pktBuf.delete();
        for (int i = 0; i < nSent * elemsPerLine; i++) begin
            pktBuf.push_back(elemT'($urandom));
        end
        for (int k = 0; k < nSent; k++) begin
            if (k > 0) begin
                repeat ($urandom_range(maxGap, 0)) driveIdle();
            end
            for (int j = 0; j < elemsPerLine; j++) begin
                line[j*elemBits +: elemBits] = pktBuf[k*elemsPerLine + j];
            end
            @(posedge clk);
            driveEdge = edgeCnt + 1; // Counter still holds the previous edge
            inValid <= 1'b1;
            inLast  <= (k == nSent - 1);
            inData  <= line;
            inOffs  <= (k == 0) ? offsT'(offs) : offsT'($urandom);       // Only the first
            inElems <= (k == 0) ? elemCountT'(elems) : elemCountT'($urandom); // line counts
            stimCycles++;
            linesSent++;
            // Line k+1 completes output k, 18 cycles from the edge it is driven on
            if (k > 0) begin
                expQ.push_back(modelLine(k - 1, offs, elems, 1'b0, driveEdge + 18));
            end
            // The last line completes in the flush cycle one edge later
            if (k == nSent - 1) begin
                expQ.push_back(modelLine(k, offs, elems, 1'b1, driveEdge + 19));
            end
        end
    endtask

    // Idle until every expected line has come out
    task automatic settle();
        driveIdle();
        while (expQ.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk); // Catches stray lines after the last one
    endtask

    task automatic applyReset();
        @(posedge clk);
        resetReq <= 1'b1;
        @(posedge clk);
        resetReq <= 1'b0;
        wait (rstN === 1'b0);
        wait (rstN === 1'b1);
        @(negedge clk);
    endtask

    task automatic checkLenError(input logic expected);
        if (lenError !== expected) begin
            errCount++;
            $display("MISMATCH lenError: got %h expected %h", lenError, expected);
        end
    endtask

    task automatic startTest();
        testErr0   = errCount;
        testLines0 = linesSeen;
    endtask

    task automatic endTest(input string name);
        testsRun++;
        $display("test %s: %0d lines checked, %0d errors", name, linesSeen - testLines0,
                 errCount - testErr0);
    endtask

    // Every offset once, random lengths and gaps
    task automatic alignTest();
        int elems;
        startTest();
        for (int offs = 0; offs < elemsPerLine; offs++) begin
            elems = $urandom_range(80, 1);
            sendPacket(offs, elems, linesFor(offs, elems), 3);
            repeat ($urandom_range(4, 1)) driveIdle();
        end
        settle();
        checkLenError(1'b0);
        endTest("align");
    endtask

    task automatic maskTest();
        int offs;
        int elems;
        startTest();
        for (int p = 0; p < 12; p++) begin
            offs  = $urandom_range(15, 0);
            elems = (p < 5) ? elemsPerLine * (p + 1) : $urandom_range(80, 1); // Full last lines
            sendPacket(offs, elems, linesFor(offs, elems), 2);
            repeat ($urandom_range(3, 0)) driveIdle();
        end
        settle();
        checkLenError(1'b0);
        endTest("mask");
    endtask

    task automatic framingTest();
        int offs;
        int elems;
        int lines0;
        int sent0;
        int last0;
        startTest();
        lines0 = linesSeen;
        sent0  = linesSent;
        last0  = lastSeen;
        for (int p = 0; p < 12; p++) begin
            offs = $urandom_range(15, 0);
            if (p % 2 == 0) begin
                elems = $urandom_range(elemsPerLine - offs, 1); // Fits in one line
            end else begin
                elems = $urandom_range(80, 1);
            end
            sendPacket(offs, elems, linesFor(offs, elems), 3);
            repeat ($urandom_range(3, 0)) driveIdle();
        end
        settle();
        if (linesSeen - lines0 != linesSent - sent0) begin
            errCount++;
            $display("%0d lines went in but %0d lines came out", linesSent - sent0,
                     linesSeen - lines0);
        end
        if (lastSeen - last0 != 12) begin
            errCount++;
            $display("12 packets were sent but outLast was seen %0d times", lastSeen - last0);
        end
        checkLenError(1'b0);
        endTest("framing");
    endtask

    // Next packet always opens in the flush cycle of the one before
    task automatic backToBackTest();
        int offs;
        int elems;
        startTest();
        for (int p = 0; p < 10; p++) begin
            offs  = $urandom_range(15, 0);
            elems = (p % 3 == 0) ? $urandom_range(elemsPerLine - offs, 1) : $urandom_range(80, 1);
            sendPacket(offs, elems, linesFor(offs, elems), 0);
        end
        settle();
        checkLenError(1'b0);
        endTest("back to back");
    endtask

    task automatic lengthTest();
        int offs;
        int elems;
        startTest();
        repeat (4) begin
            offs  = $urandom_range(15, 0);
            elems = $urandom_range(80, 1);
            sendPacket(offs, elems, linesFor(offs, elems), 2);
            repeat ($urandom_range(3, 0)) driveIdle();
        end
        settle();
        checkLenError(1'b0);
        offs  = $urandom_range(15, 0);
        elems = $urandom_range(80, 1);
        sendPacket(offs, elems, linesFor(offs, elems) + 1, 2); // One line too many
        settle();
        checkLenError(1'b1);
        offs  = $urandom_range(15, 0);
        elems = $urandom_range(80, 1);
        sendPacket(offs, elems, linesFor(offs, elems), 2);
        settle();
        checkLenError(1'b1); // Still set after a good packet
        applyReset();
        checkLenError(1'b0);
        offs  = $urandom_range(15, 0);
        elems = $urandom_range(80, 17);                         // Spans two lines or more
        sendPacket(offs, elems, linesFor(offs, elems) - 1, 2); // One line too few
        settle();
        checkLenError(1'b1);
        endTest("length");
    endtask

    task automatic resetTest();
        int offs;
        int elems;
        startTest();
        // Reset hits while a packet of three lines or more is still streaming out
        offs  = $urandom_range(15, 0);
        elems = $urandom_range(80, 33);
        sendPacket(offs, elems, linesFor(offs, elems), 0);
        repeat (14) driveIdle();
        applyReset();
        expQ.delete(); // Lines cut off by the reset never come out
        if (outValid !== 1'b0) begin
            errCount++;
            $display("MISMATCH outValid: got %h expected %h", outValid, 1'b0);
        end
        checkLenError(1'b0);
        repeat (24) driveIdle(); // A line left in the pipeline would find the model queue empty
        for (int p = 0; p < 6; p++) begin
            offs  = $urandom_range(15, 0);
            elems = $urandom_range(80, 1);
            sendPacket(offs, elems, linesFor(offs, elems), 2);
            repeat ($urandom_range(2, 0)) driveIdle();
        end
        settle();
        endTest("reset latency");
    endtask

    // Compares each output line with the model, values and cycle
    always @(negedge clk) begin : monitor
        expLineT want;
        edgeCnt++; // Now equals the rising edges so far
        if (!rstN) begin
            if (outValid !== 1'b0) begin
                errCount++;
                $display("outValid is high while reset is asserted");
            end
        end else if (outValid === 1'b1) begin
            linesSeen++;
            if (outLast) begin
                lastSeen++;
            end
            if (expQ.size() == 0) begin
                errCount++;
                $display("an output line came out at cycle %0d with none expected", edgeCnt);
            end else begin
                want = expQ.pop_front();
                if (outData !== want.data) begin
                    errCount++;
                    $display("MISMATCH outData: got %h expected %h", outData, want.data);
                end
                if (outMask !== want.mask) begin
                    errCount++;
                    $display("MISMATCH outMask: got %h expected %h", outMask, want.mask);
                end
                if (outLast !== want.last) begin
                    errCount++;
                    $display("MISMATCH outLast: got %h expected %h", outLast, want.last);
                end
                if (edgeCnt != want.dueEdge) begin
                    errCount++;
                    $display("output line came out at cycle %0d, it was due at cycle %0d",
                             edgeCnt, want.dueEdge);
                end
            end
        end
    end

    // Limit grows with the stimulus, far above the drain time of every test
    initial begin : watchdog
        while (edgeCnt <= 20 * stimCycles + 200) begin
            @(posedge clk);
        end
        $display("run stopped after %0d cycles with %0d lines still expected", edgeCnt,
                 expQ.size());
        $display("TB FAILED");
        $finish;
    end

    initial begin : stimulus
        resetReq = 1'b0;
        inValid  = 1'b0;
        inLast   = 1'b0;
        inData   = '0;
        inOffs   = '0;
        inElems  = 16'd1;
        void'($urandom(32'h0196_bcde));
        wait (rstN === 1'b1);
        alignTest();
        maskTest();
        framingTest();
        backToBackTest();
        lengthTest();
        resetTest();
        $display("tests %0d, lines checked %0d, errors %0d", testsRun, linesSeen, errCount);
        if (errCount == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: lineAligner.f
+incdir+include
hdl/alignTypesPkg.sv
hdl/alignStreamPkg.sv
hdl/windowBuilder.sv
hdl/elementShifter.sv
hdl/lineMasker.sv
hdl/lineAligner.sv
bench/clockGen.sv
bench/lineAlignerTb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module lineAlignerTb -f lineAligner.f -o simv
	./obj_dir/simv | tee sim.log
	! grep -q "TB FAILED" sim.log
	grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
